//--- Bender.yml
package:
  name: decode_frontend

sources:
  - hw/decode_pkg.sv
  - hw/rvc_expander.sv
  - hw/scalar_decoder.sv
  - hw/decode_stage.sv
  - hw/uop_queue.sv
  - hw/decode_frontend.sv
  - target: simulation
    files:
      - verification/decode_frontend_assertions.sv
      - verification/decode_frontend_tb.sv

//--- hw/decode_frontend.sv
// decode front end top level
// decode stage feeding the micro-op queue, stall returned to fetch

`timescale 1ns/1ps
`default_nettype none

module decode_frontend (
    input  logic                         CLK,
    input  logic                         rst_n,
    input  logic                         fetch_valid,
    input  logic [decode_pkg::XLEN-1:0]  fetch_pc,
    input  logic [decode_pkg::XLEN-1:0]  fetch_instr,
    input  logic                         deq,
    input  logic                         flush,
    output logic                         stall,
    output logic                         out_valid,
    output logic [decode_pkg::XLEN-1:0]  out_pc,
    output logic [decode_pkg::XLEN-1:0]  out_instr,
    output logic                         out_compressed,
    output decode_pkg::op_class_e        out_class,
    output logic [decode_pkg::REG_W-1:0] out_rd,
    output logic [decode_pkg::REG_W-1:0] out_rs1,
    output logic [decode_pkg::REG_W-1:0] out_rs2,
    output logic [decode_pkg::XLEN-1:0]  out_imm,
    output logic                         out_reg_wen,
    output logic                         out_illegal
);
    import decode_pkg::*;

    // decode stage to queue
    logic             full;
    logic             queue_wen;
    logic [XLEN-1:0]  uop_pc;
    logic [XLEN-1:0]  uop_instr;
    logic             uop_compressed;
    op_class_e        uop_class;
    logic [REG_W-1:0] uop_rd;
    logic [REG_W-1:0] uop_rs1;
    logic [REG_W-1:0] uop_rs2;
    logic [XLEN-1:0]  uop_imm;
    logic             uop_reg_wen;
    logic             uop_illegal;

    decode_stage u_decode_stage (
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_instr    (fetch_instr),
        .full           (full),
        .stall          (stall),
        .queue_wen      (queue_wen),
        .uop_pc         (uop_pc),
        .uop_instr      (uop_instr),
        .uop_compressed (uop_compressed),
        .uop_class      (uop_class),
        .uop_rd         (uop_rd),
        .uop_rs1        (uop_rs1),
        .uop_rs2        (uop_rs2),
        .uop_imm        (uop_imm),
        .uop_reg_wen    (uop_reg_wen),
        .uop_illegal    (uop_illegal)
    );

    uop_queue u_uop_queue (
        .CLK            (CLK),
        .rst_n          (rst_n),
        .wen            (queue_wen),
        .deq            (deq),
        .flush          (flush),
        .uop_pc         (uop_pc),
        .uop_instr      (uop_instr),
        .uop_compressed (uop_compressed),
        .uop_class      (uop_class),
        .uop_rd         (uop_rd),
        .uop_rs1        (uop_rs1),
        .uop_rs2        (uop_rs2),
        .uop_imm        (uop_imm),
        .uop_reg_wen    (uop_reg_wen),
        .uop_illegal    (uop_illegal),
        .full           (full),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_instr      (out_instr),
        .out_compressed (out_compressed),
        .out_class      (out_class),
        .out_rd         (out_rd),
        .out_rs1        (out_rs1),
        .out_rs2        (out_rs2),
        .out_imm        (out_imm),
        .out_reg_wen    (out_reg_wen),
        .out_illegal    (out_illegal)
    );

endmodule

`default_nettype wire

//--- hw/decode_pkg.sv
// decode front end shared definitions
// micro-op field widths, queue sizing, RV32 major opcodes and op classes

`default_nettype none

package decode_pkg;

    // datapath widths
    localparam int XLEN = 32;
    localparam int REG_W = 5;

    // micro-op queue sizing
    localparam int QUEUE_DEPTH = 4;
    localparam int PTR_W = 2;
    // one extra bit so a full queue is distinguishable from empty
    localparam int COUNT_W = 3;

    // funct3 codes needed by the RV32C expander
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_LW = 3'b010;
    localparam logic [2:0] F3_SW = 3'b010;

    // RV32C quadrant field
    localparam logic [1:0] C_Q0 = 2'b00;
    localparam logic [1:0] C_Q1 = 2'b01;
    localparam logic [1:0] C_Q2 = 2'b10;

    // RV32C funct3 codes of the supported subset
    localparam logic [2:0] CF3_ADDI = 3'b000;
    localparam logic [2:0] CF3_LI = 3'b010;
    localparam logic [2:0] CF3_LW = 3'b010;
    localparam logic [2:0] CF3_SW = 3'b110;
    // shared by C.MV and C.ADD, bit 12 tells them apart
    localparam logic [2:0] CF3_MV_ADD = 3'b100;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011
    } opcode_e;

    // decoded operation class carried by each micro-op
    typedef enum logic [3:0] {
        OPC_ALU_IMM = 4'd0,
        OPC_ALU_REG = 4'd1,
        OPC_LOAD    = 4'd2,
        OPC_STORE   = 4'd3,
        OPC_BRANCH  = 4'd4,
        // JAL and JALR
        OPC_JUMP    = 4'd5,
        // LUI and AUIPC
        OPC_UPPER   = 4'd6,
        OPC_ILLEGAL = 4'd15
    } op_class_e;

endpackage

`default_nettype wire

//--- hw/decode_stage.sv
// decode stage
// expands compressed words, decodes, and raises the queue write strobe

`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                         fetch_valid,
    input  logic [decode_pkg::XLEN-1:0]  fetch_pc,
    input  logic [decode_pkg::XLEN-1:0]  fetch_instr,
    input  logic                         full,
    output logic                         stall,
    output logic                         queue_wen,
    output logic [decode_pkg::XLEN-1:0]  uop_pc,
    output logic [decode_pkg::XLEN-1:0]  uop_instr,
    output logic                         uop_compressed,
    output decode_pkg::op_class_e        uop_class,
    output logic [decode_pkg::REG_W-1:0] uop_rd,
    output logic [decode_pkg::REG_W-1:0] uop_rs1,
    output logic [decode_pkg::REG_W-1:0] uop_rs2,
    output logic [decode_pkg::XLEN-1:0]  uop_imm,
    output logic                         uop_reg_wen,
    output logic                         uop_illegal
);
    import decode_pkg::*;

    logic [XLEN-1:0] inst32;
    logic            c_ena;
    logic            c_illegal;
    logic [XLEN-1:0] dec_instr;
    op_class_e       dec_class;
    logic            dec_reg_wen;
    logic            dec_illegal;

    rvc_expander u_rvc_expander (
        .inst16    (fetch_instr[15:0]),
        .inst32    (inst32),
        .c_ena     (c_ena),
        .c_illegal (c_illegal)
    );

    // decoder sees the expanded word for compressed input
    assign dec_instr = c_ena ? inst32 : fetch_instr;

    scalar_decoder u_scalar_decoder (
        .instr    (dec_instr),
        .op_class (dec_class),
        .rd       (uop_rd),
        .rs1      (uop_rs1),
        .rs2      (uop_rs2),
        .imm      (uop_imm),
        .reg_wen  (dec_reg_wen),
        .illegal  (dec_illegal)
    );

    // an unsupported compressed form overrides whatever the decoder saw
    assign uop_class = c_illegal ? OPC_ILLEGAL : dec_class;
    assign uop_reg_wen = dec_reg_wen && !c_illegal;
    assign uop_illegal = dec_illegal || c_illegal;

    // original word and pc pass straight through
    assign uop_pc = fetch_pc;
    assign uop_instr = fetch_instr;
    assign uop_compressed = c_ena;

    // fetch holds its word while the queue is full
    assign stall = full;
    assign queue_wen = fetch_valid && !full;

endmodule

`default_nettype wire

//--- hw/rvc_expander.sv
// RV32C expander
// rebuilds the 32-bit word for C.ADDI, C.LI, C.MV, C.ADD, C.LW and C.SW
// every other compressed encoding is flagged illegal

`timescale 1ns/1ps
`default_nettype none

module rvc_expander (
    input  logic [15:0]                 inst16,
    output logic [decode_pkg::XLEN-1:0] inst32,
    output logic                        c_ena,
    output logic                        c_illegal
);
    import decode_pkg::*;

    logic [1:0]  quad;
    logic [2:0]  cf3;
    // full-width register fields, CI and CR formats
    logic [4:0]  rd_full;
    logic [4:0]  rs2_full;
    // compact register fields mapped onto x8..x15
    logic [4:0]  rs1_prime;
    logic [4:0]  rd_prime;
    // sign-extended CI immediate
    logic [11:0] ci_imm;
    // zero-extended word offset for C.LW / C.SW
    logic [11:0] mem_off;

    assign quad = inst16[1:0];
    assign cf3 = inst16[15:13];
    assign rd_full = inst16[11:7];
    assign rs2_full = inst16[6:2];
    assign rs1_prime = {2'b01, inst16[9:7]};
    assign rd_prime = {2'b01, inst16[4:2]};
    assign ci_imm = {{6{inst16[12]}}, inst16[12], inst16[6:2]};
    // offset[6] = inst[5], offset[5:3] = inst[12:10], offset[2] = inst[6]
    assign mem_off = {5'b0, inst16[5], inst16[12:10], inst16[6], 2'b00};

    // 11 in the low bits marks a full 32-bit instruction
    assign c_ena = (quad != 2'b11);

    always_comb begin
        inst32 = '0;
        c_illegal = 1'b0;
        if (c_ena) begin
            // fall through to illegal unless a supported form matches
            c_illegal = 1'b1;
            case (quad)
                C_Q0: begin
                    if (cf3 == CF3_LW) begin
                        // lw rd', off(rs1')
                        inst32 = {mem_off, rs1_prime, F3_LW, rd_prime, OPCODE_LOAD};
                        c_illegal = 1'b0;
                    end else if (cf3 == CF3_SW) begin
                        // sw rs2', off(rs1'), offset split across S fields
                        inst32 = {mem_off[11:5], rd_prime, rs1_prime, F3_SW,
                                  mem_off[4:0], OPCODE_STORE};
                        c_illegal = 1'b0;
                    end
                end
                C_Q1: begin
                    if (cf3 == CF3_ADDI) begin
                        // addi rd, rd, imm
                        inst32 = {ci_imm, rd_full, F3_ADD, rd_full, OPCODE_OP_IMM};
                        c_illegal = 1'b0;
                    end else if (cf3 == CF3_LI) begin
                        // addi rd, x0, imm
                        inst32 = {ci_imm, 5'd0, F3_ADD, rd_full, OPCODE_OP_IMM};
                        c_illegal = 1'b0;
                    end
                end
                C_Q2: begin
                    // rs2 of zero would be C.JR / C.JALR / C.EBREAK, not kept
                    if (cf3 == CF3_MV_ADD && rs2_full != 5'd0) begin
                        if (inst16[12]) begin
                            // add rd, rd, rs2
                            inst32 = {7'b0, rs2_full, rd_full, F3_ADD, rd_full, OPCODE_OP};
                        end else begin
                            // add rd, x0, rs2
                            inst32 = {7'b0, rs2_full, 5'd0, F3_ADD, rd_full, OPCODE_OP};
                        end
                        c_illegal = 1'b0;
                    end
                end
                default: begin
                    c_illegal = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/scalar_decoder.sv
// RV32I scalar decoder
// classifies the major opcode and builds the matching immediate

`timescale 1ns/1ps
`default_nettype none

module scalar_decoder (
    input  logic [decode_pkg::XLEN-1:0]  instr,
    output decode_pkg::op_class_e        op_class,
    output logic [decode_pkg::REG_W-1:0] rd,
    output logic [decode_pkg::REG_W-1:0] rs1,
    output logic [decode_pkg::REG_W-1:0] rs2,
    output logic [decode_pkg::XLEN-1:0]  imm,
    output logic                         reg_wen,
    output logic                         illegal
);
    import decode_pkg::*;

    opcode_e         opcode;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    // class allows a write before the rd == x0 check
    logic            wen_class;

    assign opcode = opcode_e'(instr[6:0]);

    // register fields are passed on raw
    assign rd = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    // immediate formats, all sign-extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        op_class = OPC_ILLEGAL;
        imm = '0;
        wen_class = 1'b0;
        illegal = 1'b0;
        case (opcode)
            OPCODE_LUI, OPCODE_AUIPC: begin
                op_class = OPC_UPPER;
                imm = imm_u;
                wen_class = 1'b1;
            end
            OPCODE_JAL: begin
                op_class = OPC_JUMP;
                imm = imm_j;
                wen_class = 1'b1;
            end
            OPCODE_JALR: begin
                op_class = OPC_JUMP;
                imm = imm_i;
                wen_class = 1'b1;
            end
            OPCODE_BRANCH: begin
                op_class = OPC_BRANCH;
                imm = imm_b;
            end
            OPCODE_LOAD: begin
                op_class = OPC_LOAD;
                imm = imm_i;
                wen_class = 1'b1;
            end
            OPCODE_STORE: begin
                op_class = OPC_STORE;
                imm = imm_s;
            end
            OPCODE_OP_IMM: begin
                op_class = OPC_ALU_IMM;
                imm = imm_i;
                wen_class = 1'b1;
            end
            OPCODE_OP: begin
                op_class = OPC_ALU_REG;
                wen_class = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // writes to x0 are dropped here
    assign reg_wen = wen_class && (rd != '0);

endmodule

`default_nettype wire

//--- hw/uop_queue.sv
// micro-op queue
// in-order circular buffer of decoded micro-ops with flush

`timescale 1ns/1ps
`default_nettype none

module uop_queue (
    input  logic                         CLK,
    input  logic                         rst_n,
    input  logic                         wen,
    input  logic                         deq,
    input  logic                         flush,
    input  logic [decode_pkg::XLEN-1:0]  uop_pc,
    input  logic [decode_pkg::XLEN-1:0]  uop_instr,
    input  logic                         uop_compressed,
    input  decode_pkg::op_class_e        uop_class,
    input  logic [decode_pkg::REG_W-1:0] uop_rd,
    input  logic [decode_pkg::REG_W-1:0] uop_rs1,
    input  logic [decode_pkg::REG_W-1:0] uop_rs2,
    input  logic [decode_pkg::XLEN-1:0]  uop_imm,
    input  logic                         uop_reg_wen,
    input  logic                         uop_illegal,
    output logic                         full,
    output logic                         out_valid,
    output logic [decode_pkg::XLEN-1:0]  out_pc,
    output logic [decode_pkg::XLEN-1:0]  out_instr,
    output logic                         out_compressed,
    output decode_pkg::op_class_e        out_class,
    output logic [decode_pkg::REG_W-1:0] out_rd,
    output logic [decode_pkg::REG_W-1:0] out_rs1,
    output logic [decode_pkg::REG_W-1:0] out_rs2,
    output logic [decode_pkg::XLEN-1:0]  out_imm,
    output logic                         out_reg_wen,
    output logic                         out_illegal
);
    import decode_pkg::*;

    // payload storage, one array per field
    logic [XLEN-1:0]  pc_mem [QUEUE_DEPTH];
    logic [XLEN-1:0]  instr_mem [QUEUE_DEPTH];
    logic             comp_mem [QUEUE_DEPTH];
    op_class_e        class_mem [QUEUE_DEPTH];
    logic [REG_W-1:0] rd_mem [QUEUE_DEPTH];
    logic [REG_W-1:0] rs1_mem [QUEUE_DEPTH];
    logic [REG_W-1:0] rs2_mem [QUEUE_DEPTH];
    logic [XLEN-1:0]  imm_mem [QUEUE_DEPTH];
    logic             wen_mem [QUEUE_DEPTH];
    logic             ill_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [COUNT_W-1:0] count;
    logic               do_read;

    assign out_valid = (count != '0);
    assign full = (count == COUNT_W'(QUEUE_DEPTH));
    // deq only counts against a valid head
    assign do_read = deq && out_valid;

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            // same-cycle write is dropped
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (wen) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wen, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // write side
    always_ff @(posedge CLK) begin
        if (wen && !flush) begin
            pc_mem[wr_ptr] <= uop_pc;
            instr_mem[wr_ptr] <= uop_instr;
            comp_mem[wr_ptr] <= uop_compressed;
            class_mem[wr_ptr] <= uop_class;
            rd_mem[wr_ptr] <= uop_rd;
            rs1_mem[wr_ptr] <= uop_rs1;
            rs2_mem[wr_ptr] <= uop_rs2;
            imm_mem[wr_ptr] <= uop_imm;
            wen_mem[wr_ptr] <= uop_reg_wen;
            ill_mem[wr_ptr] <= uop_illegal;
        end
    end

    // head of queue, qualified by out_valid
    assign out_pc = pc_mem[rd_ptr];
    assign out_instr = instr_mem[rd_ptr];
    assign out_compressed = comp_mem[rd_ptr];
    assign out_class = class_mem[rd_ptr];
    assign out_rd = rd_mem[rd_ptr];
    assign out_rs1 = rs1_mem[rd_ptr];
    assign out_rs2 = rs2_mem[rd_ptr];
    assign out_imm = imm_mem[rd_ptr];
    assign out_reg_wen = wen_mem[rd_ptr];
    assign out_illegal = ill_mem[rd_ptr];

endmodule

`default_nettype wire

//--- sources.f
hw/decode_pkg.sv
hw/rvc_expander.sv
hw/scalar_decoder.sv
hw/decode_stage.sv
hw/uop_queue.sv
hw/decode_frontend.sv
verification/decode_frontend_assertions.sv
verification/decode_frontend_tb.sv

//--- verification/decode_frontend_assertions.sv
// decode front end protocol checks
// concurrent assertions on flush, stall, deq and reset, bound to the top level

`timescale 1ns/1ps
`default_nettype none

module decode_frontend_assertions (
    input logic CLK,
    input logic rst_n,
    input logic deq,
    input logic flush,
    input logic stall,
    input logic out_valid
);
    // read by the testbench at the end of the run
    int fail_count = 0;

    // flush empties the queue at the next edge
    flush_empties: assert property (@(posedge CLK) disable iff (!rst_n)
        flush |=> !out_valid)
    else begin
        $error("out_valid still high in the cycle after flush");
        fail_count++;
    end

    // full only clears through deq or flush
    stall_holds: assert property (@(posedge CLK) disable iff (!rst_n)
        stall && !deq && !flush |=> stall)
    else begin
        $error("stall fell while full without deq or flush");
        fail_count++;
    end

    // consumer may only pop a valid head
    deq_needs_valid: assert property (@(posedge CLK) disable iff (!rst_n)
        deq |-> out_valid)
    else begin
        $error("deq asserted while out_valid is low");
        fail_count++;
    end

    // queue comes out of reset empty
    reset_idle: assert property (@(posedge CLK)
        $rose(rst_n) |-> !out_valid && !stall)
    else begin
        $error("out_valid or stall high right after reset");
        fail_count++;
    end

endmodule

bind decode_frontend decode_frontend_assertions u_assertions (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .deq       (deq),
    .flush     (flush),
    .stall     (stall),
    .out_valid (out_valid)
);

`default_nettype wire

//--- verification/decode_frontend_tb.sv
// decode front end testbench
// drives fetch words on the falling edge, drains the micro-op queue
// and checks each head against a table built from the RV32 encodings

`timescale 1ns/1ps
`default_nettype none

module decode_frontend_tb;
    import decode_pkg::*;

    logic             CLK;
    logic             rst_n;
    logic             fetch_valid;
    logic [XLEN-1:0]  fetch_pc;
    logic [XLEN-1:0]  fetch_instr;
    logic             deq;
    logic             flush;
    logic             stall;
    logic             out_valid;
    logic [XLEN-1:0]  out_pc;
    logic [XLEN-1:0]  out_instr;
    logic             out_compressed;
    op_class_e        out_class;
    logic [REG_W-1:0] out_rd;
    logic [REG_W-1:0] out_rs1;
    logic [REG_W-1:0] out_rs2;
    logic [XLEN-1:0]  out_imm;
    logic             out_reg_wen;
    logic             out_illegal;

    // expected head records, {pc, instr, comp, class, rd, rs1, rs2, imm, wen, ill}
    logic [117:0]     exp_q[$];
    logic [117:0]     mask_q[$];
    logic             drain_en;
    logic [XLEN-1:0]  pc;
    string            cur_test;
    int               seed = 32'hd641;
    int               errors;
    int               test_errors;
    int               tests_run;
    int               tests_failed;
    // rough length of each test in cycles
    int               test_len[6] = '{10, 40, 24, 12, 24, 16};

    decode_frontend UUT (.*);

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    // RV32I encoders
    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPCODE_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], OPCODE_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, OPCODE_LUI};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
    endfunction

    function automatic logic [31:0] enc_r(logic [4:0] rs2, logic [4:0] rs1, logic [4:0] rd);
        return {7'b0, rs2, rs1, 3'b000, rd, OPCODE_OP};
    endfunction

    // one falling edge, consumer pops and checks a valid head when draining
    task automatic tick();
        logic [117:0] act;
        logic [117:0] exp;
        logic [117:0] mask;
        @(negedge CLK);
        deq = 1'b0;
        if (drain_en && out_valid) begin
            act = {out_pc, out_instr, out_compressed, out_class, out_rd, out_rs1, out_rs2,
                   out_imm, out_reg_wen, out_illegal};
            if (exp_q.size() == 0) begin
                $display("%s: a micro-op reached the head that was never sent", cur_test);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                mask = mask_q.pop_front();
                assert ((act & mask) === (exp & mask)) else begin
                    $display("FAILED %s: expected %h, actual %h", cur_test, exp & mask,
                             act & mask);
                    errors++;
                end
            end
            deq = 1'b1;
        end
    endtask

    // present one word until accepted, optionally recording its expected head
    task automatic offer(logic [31:0] word, logic [31:0] equiv, logic comp, op_class_e cls,
                         logic [31:0] imm, logic ill, logic track);
        logic [117:0] exp;
        logic [117:0] mask;
        logic [4:0]   rd;
        logic         wen;
        int           waited;
        rd = equiv[11:7];
        // no write for store, branch, x0 or an illegal word
        wen = !ill && cls != OPC_STORE && cls != OPC_BRANCH && rd != 5'd0;
        exp = {pc, word, comp, cls, rd, equiv[19:15], equiv[24:20], imm, wen, ill};
        mask = '1;
        // fields of an illegal word are don't care
        if (ill) begin
            mask[48:2] = '0;
        end
        if (track) begin
            exp_q.push_back(exp);
            mask_q.push_back(mask);
        end
        fetch_valid = 1'b1;
        fetch_pc = pc;
        fetch_instr = word;
        waited = 0;
        while (stall && waited < 16) begin
            tick();
            waited++;
        end
        if (stall) begin
            $display("%s: fetch stayed stalled for %0d cycles", cur_test, waited);
            errors++;
        end
        // accepted at the next rising edge
        tick();
        fetch_valid = 1'b0;
        pc = pc + (comp ? 32'd2 : 32'd4);
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || out_valid) && n < 32) begin
            tick();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d micro-ops never reached the head", cur_test, exp_q.size());
            errors += exp_q.size();
            exp_q.delete();
            mask_q.delete();
        end
    endtask

    task automatic check_level(string what, logic exp, logic act);
        assert (act === exp) else begin
            $display("FAILED %s: %s expected %b, actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(string name);
        cur_test = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        int e;
        e = errors - test_errors;
        tests_run++;
        if (e != 0) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d mismatches", cur_test, (e == 0) ? "ok" : "failed", e);
    endtask

    initial begin : stimulus
        logic [31:0] w;
        logic [11:0] imm12;
        logic [5:0]  imm6;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rc;
        logic [4:0]  off;
        logic [2:0]  pa;
        logic [2:0]  pb;
        int          i;
        rst_n = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc = '0;
        fetch_instr = '0;
        deq = 1'b0;
        flush = 1'b0;
        drain_en = 1'b0;
        pc = 32'h0000_1000;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (5) @(negedge CLK);
        rst_n = 1'b1;

        start_test("reset");
        tick();
        check_level("out_valid", 1'b0, out_valid);
        check_level("stall", 1'b0, stall);
        end_test();

        start_test("decode32");
        drain_en = 1'b1;
        w = enc_u(20'habcde, 5'd5);
        offer(w, w, 1'b0, OPC_UPPER, 32'habcde000, 1'b0, 1'b1);
        w = enc_j(21'h1ffff4, 5'd1);
        offer(w, w, 1'b0, OPC_JUMP, 32'hfffffff4, 1'b0, 1'b1);
        w = enc_b(13'h1ff8, 5'd4, 5'd3);
        offer(w, w, 1'b0, OPC_BRANCH, 32'hfffffff8, 1'b0, 1'b1);
        // load into x0 must not write
        w = enc_i(12'h7fc, 5'd2, 3'b010, 5'd0, OPCODE_LOAD);
        offer(w, w, 1'b0, OPC_LOAD, 32'h000007fc, 1'b0, 1'b1);
        w = enc_s(12'hffc, 5'd7, 5'd6);
        offer(w, w, 1'b0, OPC_STORE, 32'hfffffffc, 1'b0, 1'b1);
        repeat (3) begin
            imm12 = 12'($random(seed));
            ra = 5'($random(seed));
            rb = 5'($random(seed));
            rc = 5'($random(seed));
            w = enc_i(imm12, ra, 3'b000, rb, OPCODE_OP_IMM);
            offer(w, w, 1'b0, OPC_ALU_IMM, {{20{imm12[11]}}, imm12}, 1'b0, 1'b1);
            w = enc_r(rc, ra, rb);
            offer(w, w, 1'b0, OPC_ALU_REG, 32'd0, 1'b0, 1'b1);
        end
        wait_drained();
        end_test();

        start_test("compressed");
        imm6 = 6'($random(seed));
        ra = 5'($random(seed)) | 5'd1;
        rb = 5'($random(seed)) | 5'd1;
        off = 5'($random(seed));
        pa = 3'($random(seed));
        pb = 3'($random(seed));
        // c.addi rd, imm
        w = enc_i({{6{imm6[5]}}, imm6}, ra, 3'b000, ra, OPCODE_OP_IMM);
        offer({16'h0, 3'b000, imm6[5], ra, imm6[4:0], 2'b01}, w, 1'b1, OPC_ALU_IMM,
              {{26{imm6[5]}}, imm6}, 1'b0, 1'b1);
        // c.li rd, imm
        w = enc_i({{6{imm6[5]}}, imm6}, 5'd0, 3'b000, ra, OPCODE_OP_IMM);
        offer({16'h0, 3'b010, imm6[5], ra, imm6[4:0], 2'b01}, w, 1'b1, OPC_ALU_IMM,
              {{26{imm6[5]}}, imm6}, 1'b0, 1'b1);
        // c.mv and c.add
        w = enc_r(rb, 5'd0, ra);
        offer({16'h0, 4'b1000, ra, rb, 2'b10}, w, 1'b1, OPC_ALU_REG, 32'd0, 1'b0, 1'b1);
        w = enc_r(rb, ra, ra);
        offer({16'h0, 4'b1001, ra, rb, 2'b10}, w, 1'b1, OPC_ALU_REG, 32'd0, 1'b0, 1'b1);
        // c.lw and c.sw, off holds offset bits 6:2
        w = enc_i({5'b0, off, 2'b00}, {2'b01, pa}, 3'b010, {2'b01, pb}, OPCODE_LOAD);
        offer({16'h0, 3'b010, off[3:1], pa, off[0], off[4], pb, 2'b00}, w, 1'b1, OPC_LOAD,
              {25'b0, off, 2'b00}, 1'b0, 1'b1);
        w = enc_s({5'b0, off, 2'b00}, {2'b01, pb}, {2'b01, pa});
        offer({16'h0, 3'b110, off[3:1], pa, off[0], off[4], pb, 2'b00}, w, 1'b1, OPC_STORE,
              {25'b0, off, 2'b00}, 1'b0, 1'b1);
        wait_drained();
        end_test();

        start_test("illegal");
        offer(32'h0, 32'h0, 1'b1, OPC_ILLEGAL, 32'd0, 1'b1, 1'b1);
        // c.jr ra is outside the kept subset
        offer(32'h8082, 32'h8082, 1'b1, OPC_ILLEGAL, 32'd0, 1'b1, 1'b1);
        w = 32'h1234_507f;
        offer(w, w, 1'b0, OPC_ILLEGAL, 32'd0, 1'b1, 1'b1);
        wait_drained();
        end_test();

        start_test("backpressure");
        drain_en = 1'b0;
        for (i = 0; i < 4; i++) begin
            w = enc_i(12'(i + 1), 5'd1, 3'b000, 5'(i + 10), OPCODE_OP_IMM);
            offer(w, w, 1'b0, OPC_ALU_IMM, 32'(i + 1), 1'b0, 1'b1);
        end
        check_level("stall after four", 1'b1, stall);
        // fifth word waits at fetch while full
        w = enc_i(12'd5, 5'd1, 3'b000, 5'd20, OPCODE_OP_IMM);
        fetch_valid = 1'b1;
        fetch_pc = pc;
        fetch_instr = w;
        tick();
        tick();
        check_level("stall while held", 1'b1, stall);
        drain_en = 1'b1;
        offer(w, w, 1'b0, OPC_ALU_IMM, 32'd5, 1'b0, 1'b1);
        wait_drained();
        end_test();

        start_test("flush");
        drain_en = 1'b0;
        for (i = 0; i < 3; i++) begin
            w = enc_i(12'(i + 40), 5'd2, 3'b000, 5'd3, OPCODE_OP_IMM);
            offer(w, w, 1'b0, OPC_ALU_IMM, 32'(i + 40), 1'b0, 1'b0);
        end
        check_level("out_valid before flush", 1'b1, out_valid);
        flush = 1'b1;
        tick();
        flush = 1'b0;
        check_level("out_valid after flush", 1'b0, out_valid);
        check_level("stall after flush", 1'b0, stall);
        drain_en = 1'b1;
        w = enc_u(20'h12345, 5'd9);
        offer(w, w, 1'b0, OPC_UPPER, 32'h12345000, 1'b0, 1'b1);
        wait_drained();
        end_test();

        $display("summary: %0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 tests_run, tests_failed, errors, UUT.u_assertions.fail_count);
        if (errors == 0 && UUT.u_assertions.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // bound to twice the summed test lengths
    initial begin : watchdog
        int total;
        total = 0;
        foreach (test_len[k]) begin
            total += test_len[k];
        end
        #(total * 2 * 100);
        $display("watchdog: run did not finish within %0d cycles", total * 2);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
